// File: logic/panel_params.svh
// panel geometry macros shared by the packages, the engines and the testbench.
`ifndef PANEL_PARAMS_SVH
`define PANEL_PARAMS_SVH

// number of pixel columns on the panel.
`define PANEL_WIDTH 64

// number of pixel rows on the panel.
`define PANEL_HEIGHT 32

// colour bytes stored per pixel, first byte on the wire is the top byte.
`define BYTES_PER_PIXEL 3

`endif

// File: logic/panel_geom_pkg.sv
// framebuffer address and colour types, plus the colour byte selector.
`include "panel_params.svh"

package panel_geom_pkg;

    // address fields of one framebuffer byte.
    typedef logic [$clog2(`PANEL_WIDTH)-1:0] column_t;
    typedef logic [$clog2(`PANEL_HEIGHT)-1:0] row_t;
    typedef logic [$clog2(`BYTES_PER_PIXEL)-1:0] pixel_sel_t;

    // one colour, first received byte sits in the top byte.
    typedef logic [`BYTES_PER_PIXEL*8-1:0] color_t;

    // byte number sel of a colour, counted from the first received byte.
    function automatic logic [7:0] color_byte(color_t color, pixel_sel_t sel);
        int idx;
        idx = `BYTES_PER_PIXEL - 1 - int'(sel);
        return color[idx*8 +: 8];
    endfunction

endpackage

// File: logic/panel_cmd_pkg.sv
// command opcodes, engine selector and payload lengths of the host stream.
`include "panel_params.svh"

package panel_cmd_pkg;

    typedef enum logic [7:0] {
        OP_FILL_PANEL = 8'd1,
        OP_SET_PIXEL  = 8'd2
    } opcode_t;

    // which command engine owns a command.
    typedef enum logic {
        ENG_FILL = 1'b0,
        ENG_SET  = 1'b1
    } engine_t;

    // payload bytes after each opcode.
    localparam int FILL_PANEL_PAYLOAD = `BYTES_PER_PIXEL;
    localparam int SET_PIXEL_PAYLOAD = 2 + `BYTES_PER_PIXEL; // column, row, colour.

endpackage

// File: logic/cmd_dispatch.sv
// opcode decoder that routes payload bytes to an engine and records command order.
`timescale 1ns/1ns

module cmd_dispatch (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  logic [7:0]             in_data,
    output logic                   in_ready,
    output logic                   fill_valid,
    input  logic                   fill_ready,
    input  logic                   fill_payload_last,
    output logic                   set_valid,
    input  logic                   set_ready,
    input  logic                   set_payload_last,
    output logic                   order_push,
    output panel_cmd_pkg::engine_t order_engine
);
    typedef enum logic {
        ST_OPCODE,
        ST_PAYLOAD
    } state_t;

    state_t                 state;
    panel_cmd_pkg::engine_t sel;
    logic                   known_op;
    logic                   op_ready;
    logic                   sel_last;

    // decode the byte on in_data as an opcode.
    always_comb begin
        known_op = 1'b1;
        op_ready = 1'b1; // junk bytes are always taken.
        order_engine = panel_cmd_pkg::ENG_FILL;
        case (in_data)
            panel_cmd_pkg::OP_FILL_PANEL: begin
                op_ready = fill_ready;
            end
            panel_cmd_pkg::OP_SET_PIXEL: begin
                order_engine = panel_cmd_pkg::ENG_SET;
                op_ready = set_ready;
            end
            default: begin
                known_op = 1'b0;
            end
        endcase
    end

    // a known opcode waits until its engine is free again.
    assign order_push = (state == ST_OPCODE) && in_valid && known_op && op_ready;

    assign in_ready = (state == ST_OPCODE) ? op_ready :
                      (sel == panel_cmd_pkg::ENG_FILL) ? fill_ready : set_ready;

    assign fill_valid = in_valid && (state == ST_PAYLOAD) && (sel == panel_cmd_pkg::ENG_FILL);
    assign set_valid = in_valid && (state == ST_PAYLOAD) && (sel == panel_cmd_pkg::ENG_SET);

    assign sel_last = (sel == panel_cmd_pkg::ENG_FILL) ? fill_payload_last : set_payload_last;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_OPCODE;
            sel <= panel_cmd_pkg::ENG_FILL;
        end else begin
            case (state)
                ST_OPCODE: begin
                    if (order_push) begin
                        state <= ST_PAYLOAD;
                        sel <= order_engine;
                    end
                end
                default: begin
                    if (sel_last) state <= ST_OPCODE; // engine saw its final byte.
                end
            endcase
        end
    end

endmodule

// File: logic/cmd_fill_panel.sv
// fill-panel engine that captures one colour and writes it to every pixel byte.
`timescale 1ns/1ns
`include "panel_params.svh"

module cmd_fill_panel (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     byte_valid,
    input  logic [7:0]               byte_data,
    output logic                     byte_ready,
    output logic                     payload_last,
    output logic                     req_valid,
    input  logic                     req_ready,
    output panel_geom_pkg::row_t       row,
    output panel_geom_pkg::column_t    column,
    output panel_geom_pkg::pixel_sel_t pixel,
    output logic [7:0]               data,
    output logic                     cmd_end
);
    localparam int CAP_W = $clog2(panel_cmd_pkg::FILL_PANEL_PAYLOAD);

    typedef enum logic [1:0] {
        ST_CAPTURE,
        ST_RUN,
        ST_DONE
    } state_t;

    state_t                 state;
    logic [CAP_W-1:0]       cap_cnt;
    panel_geom_pkg::color_t color;
    logic                   byte_take;
    logic                   write_take;
    logic                   last_pixel;
    logic                   last_column;
    logic                   last_row;

    assign byte_ready = (state == ST_CAPTURE);
    assign byte_take = byte_valid && byte_ready;
    assign payload_last = byte_take &&
                          (cap_cnt == CAP_W'(panel_cmd_pkg::FILL_PANEL_PAYLOAD - 1));

    assign req_valid = (state == ST_RUN);
    assign write_take = req_valid && req_ready;
    assign data = panel_geom_pkg::color_byte(color, pixel);

    assign last_pixel = (pixel == panel_geom_pkg::pixel_sel_t'(`BYTES_PER_PIXEL - 1));
    assign last_column = (column == panel_geom_pkg::column_t'(`PANEL_WIDTH - 1));
    assign last_row = (row == panel_geom_pkg::row_t'(`PANEL_HEIGHT - 1));
    assign cmd_end = write_take && last_pixel && last_column && last_row;

    // colour bytes shift in from the bottom, so the first one ends on top.
    always_ff @(posedge clk) begin
        if (byte_take) color <= {color[$bits(color)-9:0], byte_data};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_CAPTURE;
            cap_cnt <= '0;
            row <= '0;
            column <= '0;
            pixel <= '0;
        end else begin
            case (state)
                ST_CAPTURE: begin
                    if (payload_last) begin
                        state <= ST_RUN;
                        row <= '0;
                        column <= '0;
                        pixel <= '0;
                    end else if (byte_take) begin
                        cap_cnt <= cap_cnt + 1'b1;
                    end
                end
                ST_RUN: begin
                    // byte fastest, then column, then row.
                    if (write_take) begin
                        if (!last_pixel) begin
                            pixel <= pixel + 1'b1;
                        end else begin
                            pixel <= '0;
                            if (!last_column) begin
                                column <= column + 1'b1;
                            end else begin
                                column <= '0;
                                row <= row + 1'b1;
                            end
                        end
                        if (cmd_end) state <= ST_DONE;
                    end
                end
                default: begin
                    state <= ST_CAPTURE;
                    cap_cnt <= '0; // ready for the next colour.
                end
            endcase
        end
    end

endmodule

// File: logic/cmd_set_pixel.sv
// set-pixel engine that captures column, row and colour and writes one pixel.
`timescale 1ns/1ns
`include "panel_params.svh"

module cmd_set_pixel (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     byte_valid,
    input  logic [7:0]               byte_data,
    output logic                     byte_ready,
    output logic                     payload_last,
    output logic                     req_valid,
    input  logic                     req_ready,
    output panel_geom_pkg::row_t       row,
    output panel_geom_pkg::column_t    column,
    output panel_geom_pkg::pixel_sel_t pixel,
    output logic [7:0]               data,
    output logic                     cmd_end
);
    localparam int CAP_W = $clog2(panel_cmd_pkg::SET_PIXEL_PAYLOAD);

    typedef enum logic [1:0] {
        ST_CAPTURE,
        ST_WRITE,
        ST_SKIP
    } state_t;

    state_t                 state;
    logic [CAP_W-1:0]       cap_cnt;
    logic [7:0]             col_byte;
    logic [7:0]             row_byte;
    panel_geom_pkg::color_t color;
    logic                   byte_take;
    logic                   in_range;
    logic                   last_pixel;

    assign byte_ready = (state == ST_CAPTURE);
    assign byte_take = byte_valid && byte_ready;
    assign payload_last = byte_take &&
                          (cap_cnt == CAP_W'(panel_cmd_pkg::SET_PIXEL_PAYLOAD - 1));

    // coordinate bytes are already stored when the last colour byte arrives.
    assign in_range = (col_byte < `PANEL_WIDTH) && (row_byte < `PANEL_HEIGHT);

    assign column = panel_geom_pkg::column_t'(col_byte);
    assign row = panel_geom_pkg::row_t'(row_byte);
    assign data = panel_geom_pkg::color_byte(color, pixel);

    assign req_valid = (state == ST_WRITE);
    assign last_pixel = (pixel == panel_geom_pkg::pixel_sel_t'(`BYTES_PER_PIXEL - 1));
    assign cmd_end = (state == ST_SKIP) || (req_valid && req_ready && last_pixel);

    always_ff @(posedge clk) begin
        if (byte_take) begin
            case (cap_cnt)
                CAP_W'(0): col_byte <= byte_data;
                CAP_W'(1): row_byte <= byte_data;
                default: color <= {color[$bits(color)-9:0], byte_data};
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_CAPTURE;
            cap_cnt <= '0;
            pixel <= '0;
        end else begin
            case (state)
                ST_CAPTURE: begin
                    if (payload_last) begin
                        state <= in_range ? ST_WRITE : ST_SKIP;
                        cap_cnt <= '0;
                        pixel <= '0;
                    end else if (byte_take) begin
                        cap_cnt <= cap_cnt + 1'b1;
                    end
                end
                ST_WRITE: begin
                    if (req_valid && req_ready) begin
                        pixel <= pixel + 1'b1;
                        if (last_pixel) state <= ST_CAPTURE;
                    end
                end
                default: state <= ST_CAPTURE; // off-panel pixel, nothing written.
            endcase
        end
    end

endmodule

// File: logic/fb_write_arbiter.sv
// framebuffer write arbiter that grants the engines in command order.
`timescale 1ns/1ns

module fb_write_arbiter (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       order_push,
    input  panel_cmd_pkg::engine_t     order_engine,
    input  logic                       fill_req_valid,
    output logic                       fill_req_ready,
    input  panel_geom_pkg::row_t       fill_row,
    input  panel_geom_pkg::column_t    fill_column,
    input  panel_geom_pkg::pixel_sel_t fill_pixel,
    input  logic [7:0]                 fill_data,
    input  logic                       fill_cmd_end,
    input  logic                       set_req_valid,
    output logic                       set_req_ready,
    input  panel_geom_pkg::row_t       set_row,
    input  panel_geom_pkg::column_t    set_column,
    input  panel_geom_pkg::pixel_sel_t set_pixel,
    input  logic [7:0]                 set_data,
    input  logic                       set_cmd_end,
    output logic                       wr_valid,
    input  logic                       wr_ready,
    output panel_geom_pkg::row_t       wr_row,
    output panel_geom_pkg::column_t    wr_column,
    output panel_geom_pkg::pixel_sel_t wr_pixel,
    output logic [7:0]                 wr_data,
    output logic                       busy
);
    // two-entry order record, slot 0 is the head.
    logic                   valid0, valid1;
    panel_cmd_pkg::engine_t eng0, eng1;
    logic                   head_fill;
    logic                   head_end, tail_end;
    logic                   keep0, keep1;

    assign head_fill = (eng0 == panel_cmd_pkg::ENG_FILL);
    assign head_end = valid0 && (head_fill ? fill_cmd_end : set_cmd_end);
    // an off-panel set-pixel may finish while still queued behind a fill.
    assign tail_end = valid1 && ((eng1 == panel_cmd_pkg::ENG_FILL) ? fill_cmd_end : set_cmd_end);
    assign keep0 = valid0 && !head_end;
    assign keep1 = valid1 && !tail_end;

    assign wr_valid = valid0 && (head_fill ? fill_req_valid : set_req_valid);
    assign wr_row = head_fill ? fill_row : set_row;
    assign wr_column = head_fill ? fill_column : set_column;
    assign wr_pixel = head_fill ? fill_pixel : set_pixel;
    assign wr_data = head_fill ? fill_data : set_data;
    assign fill_req_ready = valid0 && head_fill && wr_ready;
    assign set_req_ready = valid0 && !head_fill && wr_ready;
    assign busy = valid0;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid0 <= 1'b0;
            valid1 <= 1'b0;
            eng0 <= panel_cmd_pkg::ENG_FILL;
            eng1 <= panel_cmd_pkg::ENG_FILL;
        end else if (keep0) begin
            valid1 <= keep1 || order_push;
            if (!keep1) eng1 <= order_engine;
        end else begin
            // head leaves, the tail moves up and a push lands behind it.
            valid0 <= keep1 || order_push;
            eng0 <= keep1 ? eng1 : order_engine;
            valid1 <= keep1 && order_push;
            eng1 <= order_engine;
        end
    end

endmodule

// File: logic/panel_ctrl_top.sv
// top level of the LED panel command path, dispatcher, two engines and write arbiter.
`timescale 1ns/1ns

module panel_ctrl_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_valid,
    input  logic [7:0]                 in_data,
    output logic                       in_ready,
    output logic                       wr_valid,
    input  logic                       wr_ready,
    output panel_geom_pkg::row_t       wr_row,
    output panel_geom_pkg::column_t    wr_column,
    output panel_geom_pkg::pixel_sel_t wr_pixel,
    output logic [7:0]                 wr_data,
    output logic                       busy
);
    logic                       fill_valid, fill_ready, fill_payload_last;
    logic                       set_valid, set_ready, set_payload_last;
    logic                       order_push;
    panel_cmd_pkg::engine_t     order_engine;
    logic                       fill_req_valid, fill_req_ready, fill_cmd_end;
    panel_geom_pkg::row_t       fill_row;
    panel_geom_pkg::column_t    fill_column;
    panel_geom_pkg::pixel_sel_t fill_pixel;
    logic [7:0]                 fill_data;
    logic                       set_req_valid, set_req_ready, set_cmd_end;
    panel_geom_pkg::row_t       set_row;
    panel_geom_pkg::column_t    set_column;
    panel_geom_pkg::pixel_sel_t set_pixel;
    logic [7:0]                 set_data;

    cmd_dispatch cmd_dispatch_inst (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
        .fill_valid(fill_valid), .fill_ready(fill_ready),
        .fill_payload_last(fill_payload_last),
        .set_valid(set_valid), .set_ready(set_ready), .set_payload_last(set_payload_last),
        .order_push(order_push), .order_engine(order_engine)
    );

    cmd_fill_panel cmd_fill_panel_inst (
        .clk(clk), .reset(reset),
        .byte_valid(fill_valid), .byte_data(in_data), .byte_ready(fill_ready),
        .payload_last(fill_payload_last),
        .req_valid(fill_req_valid), .req_ready(fill_req_ready),
        .row(fill_row), .column(fill_column), .pixel(fill_pixel), .data(fill_data),
        .cmd_end(fill_cmd_end)
    );

    cmd_set_pixel cmd_set_pixel_inst (
        .clk(clk), .reset(reset),
        .byte_valid(set_valid), .byte_data(in_data), .byte_ready(set_ready),
        .payload_last(set_payload_last),
        .req_valid(set_req_valid), .req_ready(set_req_ready),
        .row(set_row), .column(set_column), .pixel(set_pixel), .data(set_data),
        .cmd_end(set_cmd_end)
    );

    fb_write_arbiter fb_write_arbiter_inst (
        .clk(clk), .reset(reset),
        .order_push(order_push), .order_engine(order_engine),
        .fill_req_valid(fill_req_valid), .fill_req_ready(fill_req_ready),
        .fill_row(fill_row), .fill_column(fill_column), .fill_pixel(fill_pixel),
        .fill_data(fill_data), .fill_cmd_end(fill_cmd_end),
        .set_req_valid(set_req_valid), .set_req_ready(set_req_ready),
        .set_row(set_row), .set_column(set_column), .set_pixel(set_pixel),
        .set_data(set_data), .set_cmd_end(set_cmd_end),
        .wr_valid(wr_valid), .wr_ready(wr_ready),
        .wr_row(wr_row), .wr_column(wr_column), .wr_pixel(wr_pixel), .wr_data(wr_data),
        .busy(busy)
    );

endmodule

// File: test/panel_ctrl_checker.sv
// testbench checker with a framebuffer model, write stall checks and image comparison.
`timescale 1ns/1ns
`include "panel_params.svh"

module panel_ctrl_checker #(
    parameter int FB_BYTES = `PANEL_WIDTH * `PANEL_HEIGHT * `BYTES_PER_PIXEL
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_ready,
    input  logic                       wr_valid,
    input  logic                       wr_ready,
    input  panel_geom_pkg::row_t       wr_row,
    input  panel_geom_pkg::column_t    wr_column,
    input  panel_geom_pkg::pixel_sel_t wr_pixel,
    input  logic [7:0]                 wr_data,
    input  logic                       busy,
    input  logic                       check_req,
    input  logic [7:0]                 expected_image [0:FB_BYTES-1],
    output int                         value_errors,
    output int                         stall_errors
);
    logic [7:0]                 fb [0:FB_BYTES-1];
    int                         value_count = 0;
    int                         stall_count = 0;
    logic                       stalled = 1'b0;
    logic                       was_reset = 1'b0;
    panel_geom_pkg::row_t       held_row;
    panel_geom_pkg::column_t    held_column;
    panel_geom_pkg::pixel_sel_t held_pixel;
    logic [7:0]                 held_data;
    int                         addr;

    assign value_errors = value_count;
    assign stall_errors = stall_count;

    initial begin : clear_fb
        int i;
        for (i = 0; i < FB_BYTES; i++) fb[i] = 8'h00;
    end

    task automatic report_value(input string name, input int expected, input int actual);
        $display("FAILED at %0t: %s expected %0h got %0h", $time, name, expected, actual);
        value_count++;
    endtask

    task automatic stall_field(input string name, input int held, input int now);
        if (held != now) begin
            $display("FAILED at %0t: %s changed during a stalled write, held %0h now %0h",
                     $time, name, held, now);
            stall_count++;
        end
    endtask

    task automatic compare_image();
        int r, c, s, idx, shown;
        shown = 0;
        for (r = 0; r < `PANEL_HEIGHT; r++) begin
            for (c = 0; c < `PANEL_WIDTH; c++) begin
                for (s = 0; s < `BYTES_PER_PIXEL; s++) begin
                    idx = (r * `PANEL_WIDTH + c) * `BYTES_PER_PIXEL + s;
                    if (fb[idx] !== expected_image[idx]) begin
                        value_count++;
                        if (shown < 8) begin
                            $display("FAILED at %0t: fb[%0d][%0d][%0d] expected %02h got %02h",
                                     $time, r, c, s, expected_image[idx], fb[idx]);
                        end
                        shown++; // only the first few are printed.
                    end
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (was_reset && !reset) begin
            if (wr_valid !== 1'b0) report_value("wr_valid", 0, int'(wr_valid));
            if (busy !== 1'b0) report_value("busy", 0, int'(busy));
            if (in_ready !== 1'b1) report_value("in_ready", 1, int'(in_ready));
        end
        was_reset = reset;
        if (reset) begin
            stalled = 1'b0;
        end else begin
            if (stalled && !wr_valid) begin
                $display("write stalled at %0t lost wr_valid before it was accepted", $time);
                stall_count++;
            end else if (stalled) begin
                stall_field("wr_row", int'(held_row), int'(wr_row));
                stall_field("wr_column", int'(held_column), int'(wr_column));
                stall_field("wr_pixel", int'(held_pixel), int'(wr_pixel));
                stall_field("wr_data", int'(held_data), int'(wr_data));
            end
            stalled = wr_valid && !wr_ready;
            held_row = wr_row;
            held_column = wr_column;
            held_pixel = wr_pixel;
            held_data = wr_data;
            if (wr_valid && wr_ready) begin
                if (int'(wr_pixel) >= `BYTES_PER_PIXEL) begin
                    $display("write at %0t uses byte index %0d beyond the pixel", $time, wr_pixel);
                    value_count++;
                end else begin
                    addr = (int'(wr_row) * `PANEL_WIDTH + int'(wr_column)) * `BYTES_PER_PIXEL
                           + int'(wr_pixel);
                    fb[addr] = wr_data;
                end
            end
            if (check_req) compare_image();
        end
    end

endmodule

// File: test/panel_ctrl_tb.sv
// testbench for the panel command path with reference image model and command sequences.
`timescale 1ns/1ns
`include "panel_params.svh"

module panel_ctrl_tb;
    localparam int W = `PANEL_WIDTH;
    localparam int H = `PANEL_HEIGHT;
    localparam int B = `BYTES_PER_PIXEL;
    localparam int FB_BYTES = W * H * B;
    localparam int COLOR_W = B * 8;
    localparam int MAX_CMDS = 64;
    localparam int WAIT_LIMIT = 20000; // longer than a full fill under back-pressure.
    localparam logic [7:0] OP_FILL = 8'd1;
    localparam logic [7:0] OP_SET = 8'd2;
    localparam logic [31:0] SEED = 32'h94f3_9365;

    logic                       clk = 1'b0;
    logic                       reset = 1'b1;
    logic                       in_valid = 1'b0;
    logic [7:0]                 in_data = 8'h00;
    logic                       in_ready;
    logic                       wr_valid;
    logic                       wr_ready = 1'b0;
    panel_geom_pkg::row_t       wr_row;
    panel_geom_pkg::column_t    wr_column;
    panel_geom_pkg::pixel_sel_t wr_pixel;
    logic [7:0]                 wr_data;
    logic                       busy;
    logic                       check_req = 1'b0;
    logic [7:0]                 expected_image [0:FB_BYTES-1];
    int                         value_errors;
    int                         stall_errors;
    int                         timeout_count = 0;
    logic [31:0]                ready_state = SEED;
    logic [31:0]                cmd_state = {SEED[15:0], SEED[31:16]};

    // commands in arrival order, junk opcodes are not kept.
    int                         cmd_count = 0;
    logic                       cmd_is_fill [0:MAX_CMDS-1];
    logic [7:0]                 cmd_col [0:MAX_CMDS-1];
    logic [7:0]                 cmd_row [0:MAX_CMDS-1];
    logic [7:0]                 cmd_color [0:MAX_CMDS-1][0:B-1];

    always #2 clk = ~clk;

    panel_ctrl_top panel_ctrl_top_inst (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
        .wr_valid(wr_valid), .wr_ready(wr_ready),
        .wr_row(wr_row), .wr_column(wr_column), .wr_pixel(wr_pixel), .wr_data(wr_data),
        .busy(busy)
    );

    panel_ctrl_checker panel_ctrl_checker_inst (
        .clk(clk), .reset(reset), .in_ready(in_ready),
        .wr_valid(wr_valid), .wr_ready(wr_ready),
        .wr_row(wr_row), .wr_column(wr_column), .wr_pixel(wr_pixel), .wr_data(wr_data),
        .busy(busy), .check_req(check_req), .expected_image(expected_image),
        .value_errors(value_errors), .stall_errors(stall_errors)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_cmd_random();
        cmd_state = xorshift32(cmd_state);
        return cmd_state;
    endfunction

    always @(negedge clk) begin
        ready_state = xorshift32(ready_state);
        wr_ready = (ready_state[1:0] != 2'b00); // ram ready about three cycles in four.
    end

    // later commands overwrite earlier ones, off-panel set-pixels touch nothing.
    function automatic logic [7:0] expected_byte(input int row, input int col, input int sel);
        logic [7:0] value;
        int k;
        value = 8'h00;
        for (k = 0; k < cmd_count; k++) begin
            if (cmd_is_fill[k]) begin
                value = cmd_color[k][sel];
            end else if (int'(cmd_col[k]) == col && int'(cmd_row[k]) == row &&
                         int'(cmd_col[k]) < W && int'(cmd_row[k]) < H) begin
                value = cmd_color[k][sel];
            end
        end
        return value;
    endfunction

    task automatic send_byte(input logic [7:0] value);
        int cycles;
        cycles = 0;
        @(negedge clk);
        in_valid = 1'b1;
        in_data = value;
        @(posedge clk);
        while (!in_ready && cycles < WAIT_LIMIT) begin
            cycles++;
            @(posedge clk);
        end
        if (!in_ready) begin
            $display("timeout at %0t: byte %02h was never accepted", $time, value);
            timeout_count++;
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(negedge clk);
        in_valid = 1'b0;
        @(posedge clk);
        while (busy && cycles < WAIT_LIMIT) begin
            cycles++;
            @(posedge clk);
        end
        if (busy) begin
            $display("timeout at %0t: busy never fell after the commands", $time);
            timeout_count++;
        end
    endtask

    task automatic record_cmd(input logic is_fill, input logic [7:0] col,
                              input logic [7:0] row, input logic [COLOR_W-1:0] color);
        int i;
        cmd_is_fill[cmd_count] = is_fill;
        cmd_col[cmd_count] = col;
        cmd_row[cmd_count] = row;
        for (i = 0; i < B; i++) cmd_color[cmd_count][i] = color[(B-1-i)*8 +: 8];
        cmd_count++;
    endtask

    task automatic fill_panel(input logic [COLOR_W-1:0] color);
        int i;
        record_cmd(1'b1, 8'd0, 8'd0, color);
        send_byte(OP_FILL);
        for (i = 0; i < B; i++) send_byte(color[(B-1-i)*8 +: 8]);
    endtask

    task automatic set_pixel(input logic [7:0] col, input logic [7:0] row,
                             input logic [COLOR_W-1:0] color);
        int i;
        record_cmd(1'b0, col, row, color);
        send_byte(OP_SET);
        send_byte(col);
        send_byte(row);
        for (i = 0; i < B; i++) send_byte(color[(B-1-i)*8 +: 8]);
    endtask

    task automatic check_image();
        int r, c, s;
        for (r = 0; r < H; r++) begin
            for (c = 0; c < W; c++) begin
                for (s = 0; s < B; s++) expected_image[(r*W + c)*B + s] = expected_byte(r, c, s);
            end
        end
        @(negedge clk);
        check_req = 1'b1;
        @(negedge clk);
        check_req = 1'b0;
    endtask

    initial begin
        logic [31:0] pick;
        logic [7:0] junk;
        int n;
        int total;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        fill_panel(COLOR_W'(32'h0012_3456));
        wait_idle();
        check_image();

        set_pixel(8'd5, 8'd7, COLOR_W'(32'h00ab_cdef));
        set_pixel(8'd63, 8'd31, COLOR_W'(32'h0001_0203));
        set_pixel(8'd0, 8'd0, COLOR_W'(32'h00fe_dcba));
        wait_idle();
        check_image();

        set_pixel(8'd64, 8'd3, COLOR_W'(32'h0055_5555));
        set_pixel(8'd10, 8'd32, COLOR_W'(32'h0066_6666));
        send_byte(8'h00);
        send_byte(8'h7f);
        set_pixel(8'd20, 8'd10, COLOR_W'(32'h0077_8899));
        wait_idle();
        check_image();

        // set-pixel queued while the fill is still writing.
        fill_panel(COLOR_W'(32'h000f_1e2d));
        set_pixel(8'd33, 8'd17, COLOR_W'(32'h00c3_c33c));
        wait_idle();
        check_image();

        for (n = 0; n < 20; n++) begin
            pick = next_cmd_random();
            case (pick[2:0])
                3'd0: fill_panel(COLOR_W'(next_cmd_random()));
                3'd1: begin
                    junk = pick[15:8];
                    if (junk == OP_FILL || junk == OP_SET) junk = 8'hee;
                    send_byte(junk);
                end
                default: set_pixel(8'(pick[15:8] % 72), 8'(pick[23:16] % 36),
                                   COLOR_W'(next_cmd_random()));
            endcase
        end
        wait_idle();
        check_image();

        total = value_errors + stall_errors + timeout_count;
        $display("errors: %0d value, %0d stall, %0d timeout", value_errors, stall_errors,
                 timeout_count);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+logic
logic/panel_geom_pkg.sv
logic/panel_cmd_pkg.sv
logic/cmd_dispatch.sv
logic/cmd_fill_panel.sv
logic/cmd_set_pixel.sv
logic/fb_write_arbiter.sv
logic/panel_ctrl_top.sv
test/panel_ctrl_checker.sv
test/panel_ctrl_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= panel_ctrl_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
